//--- veerwolf_io.f
logic/veerwolf_io_pkg.sv
logic/axil_reg_bridge.sv
logic/io_addr_decoder.sv
logic/syscon_regs.sv
logic/gpio_regs.sv
logic/veerwolf_io.sv
test/tb_veerwolf_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_veerwolf_io \
   -f veerwolf_io.f \
   -o tb_veerwolf_io
./obj_dir/tb_veerwolf_io

//--- test/tb_veerwolf_io.sv
// I/O subsystem random testbench
`timescale 1ns/1ps

module tb_veerwolf_io import veerwolf_io_pkg::*; ();

   localparam int          NUM_TXN     = 400;
   localparam int          TXN_CYCLES  = 20;
   localparam int          CLK_PERIOD  = 100;
   localparam int          WATCHDOG_NS = (NUM_TXN + 20) * TXN_CYCLES * CLK_PERIOD;
   localparam int unsigned SEED        = 32'h2673e8df;

   // Listed offsets plus a few unlisted in-region ones
   localparam logic [ADDR_W-1:0] ADDR_TABLE [15] = '{
      16'h1000, 16'h1004, 16'h1008, 16'h1010, 16'h1014, 16'h1018, 16'h101C, 16'h100C,
      16'h1020, 16'h1400, 16'h1404, 16'h1408, 16'h140C, 16'h1410, 16'h1414
   };

   logic        clk = 1'b0;
   logic        i_arst_n;
   axil_req_t   i_axil;
   axil_rsp_t   o_axil;
   logic [31:0] i_gpio;
   logic [31:0] o_gpio;
   logic [31:0] o_gpio_oe;
   logic        o_gpio_irq;
   logic        i_ram_init_done;
   logic        i_ram_init_error;
   logic        o_timer_irq;
   logic        o_sw_irq3;
   logic        o_sw_irq4;
   logic [31:0] o_nmi_vec;

   // Register model
   logic [31:0] m_out;
   logic [31:0] m_oe;
   logic [31:0] m_irq_en;
   logic [31:0] m_irq_stat;
   logic [31:0] m_nmi;
   logic [1:0]  m_swirq;
   logic [63:0] m_cmp;
   logic [63:0] last_mtime;
   logic        have_mtime;

   veerwolf_io #(
      .GPIO_WIDTH (32)
   ) u_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Done: errors found");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [31:0] merge_strb(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
      logic [31:0] res;
      res = old;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = data[8*i +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic is_mapped(input logic [ADDR_W-1:0] addr);
      return ((addr & REGION_MASK) == SYSCON_BASE) || ((addr & REGION_MASK) == GPIO_BASE);
   endfunction

   function automatic logic [ADDR_W-1:0] pick_addr();
      logic [ADDR_W-1:0] a;
      logic [3:0]        idx;
      if ($urandom % 8 == 0) begin
         a = ADDR_W'($urandom) & 16'hFFFC;
         if (is_mapped(a)) begin
            a = a ^ 16'h8000;
         end
      end else begin
         idx = 4'($urandom % 15);
         a   = ADDR_TABLE[idx];
      end
      return a;
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      logic [31:0] mask;
      mask = merge_strb(32'h0, 32'hFFFF_FFFF, strb);
      case (addr)
         SYSCON_BASE | SYS_SWIRQ: begin
            if (strb[0]) begin
               m_swirq = data[1:0];
            end
         end
         SYSCON_BASE | SYS_NMI_VEC:     m_nmi = merge_strb(m_nmi, data, strb);
         SYSCON_BASE | SYS_MTIMECMP_LO: m_cmp[31:0] = merge_strb(m_cmp[31:0], data, strb);
         SYSCON_BASE | SYS_MTIMECMP_HI: m_cmp[63:32] = merge_strb(m_cmp[63:32], data, strb);
         GPIO_BASE | GPIO_OUT:          m_out = merge_strb(m_out, data, strb);
         GPIO_BASE | GPIO_OE:           m_oe = merge_strb(m_oe, data, strb);
         GPIO_BASE | GPIO_IRQ_EN:       m_irq_en = merge_strb(m_irq_en, data, strb);
         GPIO_BASE | GPIO_IRQ_STAT:     m_irq_stat = m_irq_stat & ~(data & mask);
         default: ;
      endcase
   endtask

   function automatic logic [31:0] expected_read(input logic [ADDR_W-1:0] addr);
      case (addr)
         SYSCON_BASE | SYS_STATUS:      return {30'b0, i_ram_init_error, i_ram_init_done};
         SYSCON_BASE | SYS_SWIRQ:       return {30'b0, m_swirq};
         SYSCON_BASE | SYS_NMI_VEC:     return m_nmi;
         SYSCON_BASE | SYS_MTIMECMP_LO: return m_cmp[31:0];
         SYSCON_BASE | SYS_MTIMECMP_HI: return m_cmp[63:32];
         GPIO_BASE | GPIO_IN:           return i_gpio;
         GPIO_BASE | GPIO_OUT:          return m_out;
         GPIO_BASE | GPIO_OE:           return m_oe;
         GPIO_BASE | GPIO_IRQ_EN:       return m_irq_en;
         GPIO_BASE | GPIO_IRQ_STAT:     return m_irq_stat;
         default:                       return 32'h0;
      endcase
   endfunction

   task automatic check_outputs();
      check_value("o_gpio", 64'(o_gpio), 64'(m_out));
      check_value("o_gpio_oe", 64'(o_gpio_oe), 64'(m_oe));
      check_value("o_sw_irq3", 64'(o_sw_irq3), 64'(m_swirq[0]));
      check_value("o_sw_irq4", 64'(o_sw_irq4), 64'(m_swirq[1]));
      check_value("o_nmi_vec", 64'(o_nmi_vec), 64'(m_nmi));
      check_value("o_gpio_irq", 64'(o_gpio_irq), 64'(|(m_irq_stat & m_irq_en)));
      // mtime stays far below 2^32 during the run
      if (m_cmp == 64'h0) begin
         check_value("o_timer_irq", 64'(o_timer_irq), 64'(1));
      end else if (m_cmp[63:32] != 32'h0) begin
         check_value("o_timer_irq", 64'(o_timer_irq), 64'(0));
      end
   endtask

   // ************************************************************
   // AXI4-Lite driver
   // ************************************************************

   task automatic write_access(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
      logic [1:0] exp_resp;
      int         delay;
      exp_resp = is_mapped(addr) ? RESP_OKAY : RESP_SLVERR;
      delay    = $urandom % 4;
      @(negedge clk);
      i_axil.awvalid = 1'b1;
      i_axil.awaddr  = addr;
      i_axil.wvalid  = 1'b1;
      i_axil.wdata   = data;
      i_axil.wstrb   = strb;
      #1;
      while (!o_axil.awready) begin
         @(negedge clk);
         #1;
      end
      check_value("wready", 64'(o_axil.wready), 64'(1));
      check_value("bvalid", 64'(o_axil.bvalid), 64'(0));
      @(negedge clk);
      i_axil.awvalid = 1'b0;
      i_axil.wvalid  = 1'b0;
      i_axil.bready  = (delay == 0);
      #1;
      check_value("bvalid", 64'(o_axil.bvalid), 64'(1));
      check_value("bresp", 64'(o_axil.bresp), 64'(exp_resp));
      for (int i = 1; i <= delay; i++) begin
         @(negedge clk);
         i_axil.bready = (i == delay);
         #1;
         check_value("bvalid", 64'(o_axil.bvalid), 64'(1));
         check_value("bresp", 64'(o_axil.bresp), 64'(exp_resp));
      end
      @(negedge clk);
      i_axil.bready = 1'b0;
      #1;
      check_value("bvalid", 64'(o_axil.bvalid), 64'(0));
      model_write(addr, data, strb);
      check_outputs();
   endtask

   task automatic read_access(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                              output logic [1:0] resp);
      int delay;
      delay = $urandom % 4;
      @(negedge clk);
      i_axil.arvalid = 1'b1;
      i_axil.araddr  = addr;
      #1;
      while (!o_axil.arready) begin
         @(negedge clk);
         #1;
      end
      check_value("rvalid", 64'(o_axil.rvalid), 64'(0));
      @(negedge clk);
      i_axil.arvalid = 1'b0;
      i_axil.rready  = (delay == 0);
      #1;
      check_value("rvalid", 64'(o_axil.rvalid), 64'(1));
      data = o_axil.rdata;
      resp = o_axil.rresp;
      for (int i = 1; i <= delay; i++) begin
         @(negedge clk);
         i_axil.rready = (i == delay);
         #1;
         check_value("rvalid", 64'(o_axil.rvalid), 64'(1));
         check_value("rdata", 64'(o_axil.rdata), 64'(data));
         check_value("rresp", 64'(o_axil.rresp), 64'(resp));
      end
      @(negedge clk);
      i_axil.rready = 1'b0;
      #1;
      check_value("rvalid", 64'(o_axil.rvalid), 64'(0));
   endtask

   task automatic check_read(input logic [ADDR_W-1:0] addr);
      logic [31:0] data;
      logic [1:0]  resp;
      read_access(addr, data, resp);
      check_value("rdata", 64'(data), 64'(expected_read(addr)));
      check_value("rresp", 64'(resp), 64'(is_mapped(addr) ? RESP_OKAY : RESP_SLVERR));
   endtask

   // High word read twice so a carry between the halves is caught
   task automatic sample_mtime();
      logic [31:0] hi1;
      logic [31:0] lo;
      logic [31:0] hi2;
      logic [1:0]  resp;
      logic [63:0] now;
      read_access(SYSCON_BASE | SYS_MTIME_HI, hi1, resp);
      check_value("rresp", 64'(resp), 64'(RESP_OKAY));
      read_access(SYSCON_BASE | SYS_MTIME_LO, lo, resp);
      check_value("rresp", 64'(resp), 64'(RESP_OKAY));
      read_access(SYSCON_BASE | SYS_MTIME_HI, hi2, resp);
      check_value("rresp", 64'(resp), 64'(RESP_OKAY));
      if (hi1 == hi2) begin
         now = {hi2, lo};
         if (have_mtime) begin
            check_value("mtime increasing", 64'(now > last_mtime), 64'(1));
         end
         last_mtime = now;
         have_mtime = 1'b1;
      end
   endtask

   // Pins held long enough to pass the synchronizer and edge stage
   task automatic change_pins(input logic [31:0] pins);
      @(negedge clk);
      m_irq_stat       = m_irq_stat | (pins & ~i_gpio & m_irq_en);
      i_gpio           = pins;
      i_ram_init_done  = 1'($urandom);
      i_ram_init_error = 1'($urandom);
      repeat (5) @(negedge clk);
      #1;
      check_outputs();
   endtask

   // ************************************************************
   // Main sequence
   // ************************************************************

   initial begin
      logic [ADDR_W-1:0] addr;
      void'($urandom(SEED));
      i_arst_n         = 1'b0;
      i_axil           = '0;
      i_gpio           = 32'h0;
      i_ram_init_done  = 1'b0;
      i_ram_init_error = 1'b0;
      m_out            = 32'h0;
      m_oe             = 32'h0;
      m_irq_en         = 32'h0;
      m_irq_stat       = 32'h0;
      m_nmi            = 32'h0;
      m_swirq          = 2'b00;
      m_cmp            = '1;
      last_mtime       = 64'h0;
      have_mtime       = 1'b0;
      repeat (2) @(negedge clk);
      i_arst_n = 1'b1;
      #1;
      check_value("awready", 64'(o_axil.awready), 64'(0));
      check_value("wready", 64'(o_axil.wready), 64'(0));
      check_value("arready", 64'(o_axil.arready), 64'(0));
      check_value("bvalid", 64'(o_axil.bvalid), 64'(0));
      check_value("rvalid", 64'(o_axil.rvalid), 64'(0));
      check_outputs();

      // Timer compare at zero and then back to all ones
      write_access(SYSCON_BASE | SYS_MTIMECMP_LO, 32'h0, 4'hF);
      write_access(SYSCON_BASE | SYS_MTIMECMP_HI, 32'h0, 4'hF);
      write_access(SYSCON_BASE | SYS_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF);
      write_access(SYSCON_BASE | SYS_MTIMECMP_LO, 32'hFFFF_FFFF, 4'hF);

      // Pin 0 enabled and pin 1 disabled
      write_access(GPIO_BASE | GPIO_IRQ_EN, 32'h1, 4'hF);
      change_pins(32'h3);
      check_read(GPIO_BASE | GPIO_IRQ_STAT);
      write_access(GPIO_BASE | GPIO_IRQ_STAT, 32'h1, 4'h1);
      change_pins(32'h0);

      for (int n = 0; n < NUM_TXN; n++) begin
         addr = pick_addr();
         if ($urandom % 8 == 0) begin
            change_pins($urandom);
         end
         if ($urandom % 2 == 0) begin
            write_access(addr, $urandom, 4'($urandom));
         end else if (addr == (SYSCON_BASE | SYS_MTIME_LO) ||
                      addr == (SYSCON_BASE | SYS_MTIME_HI)) begin
            sample_mtime();
         end else begin
            check_read(addr);
         end
      end
      $display("Done: no errors");
      $finish;
   end

   initial begin
      #WATCHDOG_NS;
      $display("Timeout: the transactions did not complete in the expected time");
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- logic/veerwolf_io.sv
// VeeRwolf I/O subsystem top
`timescale 1ns/1ps

module veerwolf_io import veerwolf_io_pkg::*; #(
   parameter int GPIO_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  axil_req_t             i_axil,
   output axil_rsp_t             o_axil,
   input  logic [GPIO_WIDTH-1:0] i_gpio,
   output logic [GPIO_WIDTH-1:0] o_gpio,
   output logic [GPIO_WIDTH-1:0] o_gpio_oe,
   output logic                  o_gpio_irq,
   input  logic                  i_ram_init_done,
   input  logic                  i_ram_init_error,
   output logic                  o_timer_irq,
   output logic                  o_sw_irq3,
   output logic                  o_sw_irq4,
   output logic [DATA_W-1:0]     o_nmi_vec
);

   regbus_req_t       bus_req;
   regbus_rsp_t       bus_rsp;
   regbus_req_t       sys_req;
   regbus_req_t       gpio_req;
   logic [DATA_W-1:0] sys_rdata;
   logic [DATA_W-1:0] gpio_rdata;

   axil_reg_bridge u_bridge (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_axil   (i_axil),
      .o_axil   (o_axil),
      .o_reg    (bus_req),
      .i_reg    (bus_rsp)
   );

   io_addr_decoder u_decoder (
      .i_reg        (bus_req),
      .o_reg        (bus_rsp),
      .o_sys_req    (sys_req),
      .i_sys_rdata  (sys_rdata),
      .o_gpio_req   (gpio_req),
      .i_gpio_rdata (gpio_rdata)
   );

   syscon_regs u_syscon (
      .clk              (clk),
      .i_arst_n         (i_arst_n),
      .i_req            (sys_req),
      .o_rdata          (sys_rdata),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_timer_irq      (o_timer_irq),
      .o_sw_irq3        (o_sw_irq3),
      .o_sw_irq4        (o_sw_irq4),
      .o_nmi_vec        (o_nmi_vec)
   );

   gpio_regs #(
      .GPIO_WIDTH (GPIO_WIDTH)
   ) u_gpio (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_req      (gpio_req),
      .o_rdata    (gpio_rdata),
      .i_gpio     (i_gpio),
      .o_gpio     (o_gpio),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (o_gpio_irq)
   );

endmodule

//--- logic/gpio_regs.sv
// GPIO registers and edge interrupts
`timescale 1ns/1ps

module gpio_regs import veerwolf_io_pkg::*; #(
   parameter int GPIO_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  regbus_req_t           i_req,
   output logic [DATA_W-1:0]     o_rdata,
   input  logic [GPIO_WIDTH-1:0] i_gpio,
   output logic [GPIO_WIDTH-1:0] o_gpio,
   output logic [GPIO_WIDTH-1:0] o_gpio_oe,
   output logic                  o_gpio_irq
);

   logic [GPIO_WIDTH-1:0] gpio_meta;
   logic [GPIO_WIDTH-1:0] gpio_sync;
   logic [GPIO_WIDTH-1:0] gpio_prev;
   logic [GPIO_WIDTH-1:0] gpio_out;
   logic [GPIO_WIDTH-1:0] gpio_oe;
   logic [GPIO_WIDTH-1:0] irq_en;
   logic [GPIO_WIDTH-1:0] irq_stat;
   logic [GPIO_WIDTH-1:0] rise;
   logic [GPIO_WIDTH-1:0] w1c;
   logic                  wr_en;

   assign wr_en = i_req.valid & i_req.we;
   // Enabled rising edges only
   assign rise  = gpio_sync & ~gpio_prev & irq_en;
   assign w1c   = (wr_en && i_req.addr == GPIO_IRQ_STAT) ?
                  GPIO_WIDTH'(i_req.wdata & strb_mask(i_req.wstrb)) : '0;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         gpio_meta <= '0;
         gpio_sync <= '0;
         gpio_prev <= '0;
         gpio_out  <= '0;
         gpio_oe   <= '0;
         irq_en    <= '0;
         irq_stat  <= '0;
      end else begin
         gpio_meta <= i_gpio;
         gpio_sync <= gpio_meta;
         gpio_prev <= gpio_sync;
         // New edge beats a clear in the same cycle
         irq_stat  <= (irq_stat & ~w1c) | rise;
         if (wr_en) begin
            case (i_req.addr)
               GPIO_OUT: begin
                  gpio_out <= GPIO_WIDTH'(apply_strb(DATA_W'(gpio_out), i_req.wdata,
                                                     i_req.wstrb));
               end
               GPIO_OE: begin
                  gpio_oe <= GPIO_WIDTH'(apply_strb(DATA_W'(gpio_oe), i_req.wdata,
                                                    i_req.wstrb));
               end
               GPIO_IRQ_EN: begin
                  irq_en <= GPIO_WIDTH'(apply_strb(DATA_W'(irq_en), i_req.wdata,
                                                   i_req.wstrb));
               end
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (i_req.addr)
         GPIO_IN:       o_rdata = DATA_W'(gpio_sync);
         GPIO_OUT:      o_rdata = DATA_W'(gpio_out);
         GPIO_OE:       o_rdata = DATA_W'(gpio_oe);
         GPIO_IRQ_EN:   o_rdata = DATA_W'(irq_en);
         GPIO_IRQ_STAT: o_rdata = DATA_W'(irq_stat);
         default:       o_rdata = '0;
      endcase
   end

   assign o_gpio     = gpio_out;
   assign o_gpio_oe  = gpio_oe;
   assign o_gpio_irq = |(irq_stat & irq_en);

endmodule

//--- logic/syscon_regs.sv
// System controller registers
`timescale 1ns/1ps

module syscon_regs import veerwolf_io_pkg::*; (
   input  logic              clk,
   input  logic              i_arst_n,
   input  regbus_req_t       i_req,
   output logic [DATA_W-1:0] o_rdata,
   input  logic              i_ram_init_done,
   input  logic              i_ram_init_error,
   output logic              o_timer_irq,
   output logic              o_sw_irq3,
   output logic              o_sw_irq4,
   output logic [DATA_W-1:0] o_nmi_vec
);

   logic [63:0]       mtime;
   logic [63:0]       mtimecmp;
   logic [1:0]        sw_irq;
   logic [DATA_W-1:0] nmi_vec;
   logic              wr_en;

   assign wr_en = i_req.valid & i_req.we;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime       <= '0;
         mtimecmp    <= '1;
         sw_irq      <= '0;
         nmi_vec     <= '0;
         o_timer_irq <= 1'b0;
      end else begin
         mtime       <= mtime + 64'd1;
         o_timer_irq <= (mtime >= mtimecmp);
         if (wr_en) begin
            case (i_req.addr)
               SYS_SWIRQ: begin
                  if (i_req.wstrb[0]) begin
                     sw_irq <= i_req.wdata[1:0];
                  end
               end
               SYS_NMI_VEC: nmi_vec <= apply_strb(nmi_vec, i_req.wdata, i_req.wstrb);
               SYS_MTIMECMP_LO: begin
                  mtimecmp[31:0] <= apply_strb(mtimecmp[31:0], i_req.wdata, i_req.wstrb);
               end
               SYS_MTIMECMP_HI: begin
                  mtimecmp[63:32] <= apply_strb(mtimecmp[63:32], i_req.wdata, i_req.wstrb);
               end
               default: ;
            endcase
         end
      end
   end

   // Read mux by offset
   always_comb begin
      case (i_req.addr)
         SYS_STATUS:      o_rdata = {{(DATA_W-2){1'b0}}, i_ram_init_error, i_ram_init_done};
         SYS_SWIRQ:       o_rdata = {{(DATA_W-2){1'b0}}, sw_irq};
         SYS_NMI_VEC:     o_rdata = nmi_vec;
         SYS_MTIME_LO:    o_rdata = mtime[31:0];
         SYS_MTIME_HI:    o_rdata = mtime[63:32];
         SYS_MTIMECMP_LO: o_rdata = mtimecmp[31:0];
         SYS_MTIMECMP_HI: o_rdata = mtimecmp[63:32];
         default:         o_rdata = '0;
      endcase
   end

   assign o_sw_irq3 = sw_irq[0];
   assign o_sw_irq4 = sw_irq[1];
   assign o_nmi_vec = nmi_vec;

endmodule

//--- logic/io_addr_decoder.sv
// I/O region decoder
`timescale 1ns/1ps

module io_addr_decoder import veerwolf_io_pkg::*; (
   input  regbus_req_t       i_reg,
   output regbus_rsp_t       o_reg,
   output regbus_req_t       o_sys_req,
   input  logic [DATA_W-1:0] i_sys_rdata,
   output regbus_req_t       o_gpio_req,
   input  logic [DATA_W-1:0] i_gpio_rdata
);

   logic              sys_hit;
   logic              gpio_hit;
   logic [ADDR_W-1:0] offset;

   assign sys_hit  = (i_reg.addr & REGION_MASK) == SYSCON_BASE;
   assign gpio_hit = (i_reg.addr & REGION_MASK) == GPIO_BASE;
   assign offset   = i_reg.addr & ~REGION_MASK;

   // Peripherals see the in-region offset only
   always_comb begin
      o_sys_req       = i_reg;
      o_sys_req.addr  = offset;
      o_sys_req.valid = i_reg.valid & sys_hit;

      o_gpio_req       = i_reg;
      o_gpio_req.addr  = offset;
      o_gpio_req.valid = i_reg.valid & gpio_hit;
   end

   always_comb begin
      if (sys_hit) begin
         o_reg.rdata = i_sys_rdata;
      end else if (gpio_hit) begin
         o_reg.rdata = i_gpio_rdata;
      end else begin
         o_reg.rdata = '0;
      end
      // Unmapped access
      o_reg.err = ~sys_hit & ~gpio_hit;
   end

endmodule

//--- logic/axil_reg_bridge.sv
// AXI4-Lite to register bus bridge
`timescale 1ns/1ps

module axil_reg_bridge import veerwolf_io_pkg::*; (
   input  logic        clk,
   input  logic        i_arst_n,
   input  axil_req_t   i_axil,
   output axil_rsp_t   o_axil,
   output regbus_req_t o_reg,
   input  regbus_rsp_t i_reg
);

   logic              idle;
   logic              wr_go;
   logic              rd_go;
   logic              bvalid_q;
   logic              rvalid_q;
   logic [1:0]        bresp_q;
   logic [1:0]        rresp_q;
   logic [DATA_W-1:0] rdata_q;

   // ************************************************************
   // Arbitration with one transaction in flight
   // ************************************************************

   assign idle  = ~bvalid_q & ~rvalid_q;
   // Write wins a tie with a read
   assign wr_go = idle & i_axil.awvalid & i_axil.wvalid;
   assign rd_go = idle & i_axil.arvalid & ~wr_go;

   always_comb begin
      o_axil.awready = wr_go;
      o_axil.wready  = wr_go;
      o_axil.bvalid  = bvalid_q;
      o_axil.bresp   = bresp_q;
      o_axil.arready = rd_go;
      o_axil.rvalid  = rvalid_q;
      o_axil.rdata   = rdata_q;
      o_axil.rresp   = rresp_q;
   end

   // Register access lives only in the handshake cycle
   always_comb begin
      o_reg.valid = wr_go | rd_go;
      o_reg.we    = wr_go;
      o_reg.addr  = wr_go ? i_axil.awaddr : i_axil.araddr;
      o_reg.wdata = i_axil.wdata;
      o_reg.wstrb = i_axil.wstrb;
   end

   // ************************************************************
   // Response channels
   // ************************************************************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_go) begin
            bvalid_q <= 1'b1;
         end else if (i_axil.bready) begin
            bvalid_q <= 1'b0;
         end
         if (rd_go) begin
            rvalid_q <= 1'b1;
         end else if (i_axil.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // Payload held until the master takes it
   always_ff @(posedge clk) begin
      if (wr_go) begin
         bresp_q <= i_reg.err ? RESP_SLVERR : RESP_OKAY;
      end
      if (rd_go) begin
         rresp_q <= i_reg.err ? RESP_SLVERR : RESP_OKAY;
         rdata_q <= i_reg.err ? '0 : i_reg.rdata;
      end
   end

endmodule

//--- logic/veerwolf_io_pkg.sv
// VeeRwolf I/O subsystem definitions
package veerwolf_io_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Peripheral regions of 0x100 bytes each
   localparam logic [ADDR_W-1:0] SYSCON_BASE = 16'h1000;
   localparam logic [ADDR_W-1:0] GPIO_BASE   = 16'h1400;
   localparam logic [ADDR_W-1:0] REGION_MASK = 16'hFF00;

   // System controller offsets
   localparam logic [ADDR_W-1:0] SYS_STATUS      = 16'h0000;
   localparam logic [ADDR_W-1:0] SYS_SWIRQ       = 16'h0004;
   localparam logic [ADDR_W-1:0] SYS_NMI_VEC     = 16'h0008;
   localparam logic [ADDR_W-1:0] SYS_MTIME_LO    = 16'h0010;
   localparam logic [ADDR_W-1:0] SYS_MTIME_HI    = 16'h0014;
   localparam logic [ADDR_W-1:0] SYS_MTIMECMP_LO = 16'h0018;
   localparam logic [ADDR_W-1:0] SYS_MTIMECMP_HI = 16'h001C;

   // GPIO offsets
   localparam logic [ADDR_W-1:0] GPIO_IN       = 16'h0000;
   localparam logic [ADDR_W-1:0] GPIO_OUT      = 16'h0004;
   localparam logic [ADDR_W-1:0] GPIO_OE       = 16'h0008;
   localparam logic [ADDR_W-1:0] GPIO_IRQ_EN   = 16'h000C;
   localparam logic [ADDR_W-1:0] GPIO_IRQ_STAT = 16'h0010;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef struct packed {
      logic              awvalid;
      logic [ADDR_W-1:0] awaddr;
      logic              wvalid;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      logic              bready;
      logic              arvalid;
      logic [ADDR_W-1:0] araddr;
      logic              rready;
   } axil_req_t;

   typedef struct packed {
      logic              awready;
      logic              wready;
      logic              bvalid;
      logic [1:0]        bresp;
      logic              arready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic [1:0]        rresp;
   } axil_rsp_t;

   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } regbus_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              err;
   } regbus_rsp_t;

   // Byte lanes to bit mask
   function automatic logic [DATA_W-1:0] strb_mask(input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] mask;
      for (int i = 0; i < STRB_W; i++) begin
         mask[8*i +: 8] = {8{strb[i]}};
      end
      return mask;
   endfunction

   function automatic logic [DATA_W-1:0] apply_strb(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] wdata,
                                                    input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] mask;
      mask = strb_mask(strb);
      return (old & ~mask) | (wdata & mask);
   endfunction

endpackage
